// ==== design/conv_acc_defs.svh ====
`ifndef CONV_ACC_DEFS_SVH
`define CONV_ACC_DEFS_SVH

// ram word width, one word carries all lanes
`define DATA_BITS 32

// words per buffer, weight and feature alike
`define BUF_DEPTH 64

// address width for BUF_DEPTH words
`define BUF_ADDR_BITS 6

// run length field, legal values 1 to BUF_DEPTH
`define LEN_BITS 7

// lanes per word and bits per lane
`define LANES 4
`define LANE_BITS 8

`endif

// ==== design/mem_pkg.sv ====
`include "conv_acc_defs.svh"

package mem_pkg;

  typedef logic [`BUF_ADDR_BITS-1:0] addr_t;
  typedef logic [`DATA_BITS-1:0] data_t;

  // host side strobes and data, one access per cycle
  typedef struct packed {
    logic  load_begin;
    logic  load_done;
    logic  wr;
    logic  rd;
    // 0 selects weights, 1 selects features
    logic  buf_sel;
    addr_t addr;
    data_t wdata;
  } host_req_t;

  // single access onto one sram
  typedef struct packed {
    logic  cs;
    logic  we;
    addr_t addr;
    data_t wdata;
  } ram_req_t;

  // who owns the weight sram
  typedef enum logic [1:0] {
    IDLE   = 2'h0,
    HOST_W = 2'h1,
    EPU_RW = 2'h2
  } own_state_t;

endpackage

// ==== design/epu_pkg.sv ====
`include "conv_acc_defs.svh"

package epu_pkg;

  // one lane of each operand
  typedef logic signed [`LANE_BITS-1:0] weight_t;
  typedef logic [`LANE_BITS-1:0] feat_t;

  // lane 0 sits in the low byte of the ram word
  typedef weight_t [`LANES-1:0] weight_vec_t;
  typedef feat_t [`LANES-1:0] feat_vec_t;

  // signed x unsigned lane product, one bit wider than both operands
  typedef logic signed [2*`LANE_BITS:0] prod_t;

  // running sum, wraps on overflow
  typedef logic signed [`DATA_BITS-1:0] acc_t;

  typedef enum logic [1:0] {
    IDLE  = 2'h0,
    RUN   = 2'h1,
    DRAIN = 2'h2
  } epu_state_t;

endpackage

// ==== design/sp_ram.sv ====
`timescale 1ns/1ps
`include "conv_acc_defs.svh"

module sp_ram #(
  parameter type word_t = logic [`DATA_BITS-1:0],
  parameter int DEPTH = `BUF_DEPTH
) (
  input  logic              clk,
  input  mem_pkg::ram_req_t req_i,
  output word_t             rdata_o
);

  word_t mem [DEPTH];

  // write wins, a read returns the word after one clock
  always_ff @(posedge clk) begin
    if (req_i.cs) begin
      if (req_i.we) begin
        mem[req_i.addr] <= word_t'(req_i.wdata);
      end else begin
        rdata_o <= mem[req_i.addr];
      end
    end
  end

endmodule

// ==== design/weight_wrapper.sv ====
`timescale 1ns/1ps
`include "conv_acc_defs.svh"

module weight_wrapper (
  input  logic                  clk,
  input  logic                  rst,
  input  mem_pkg::host_req_t    host_i,
  input  logic                  busy_i,
  input  mem_pkg::ram_req_t     epu_req_i,
  output epu_pkg::weight_vec_t  weight_o,
  output logic                  rvalid_o,
  output logic [`DATA_BITS-1:0] rdata_o,
  output logic                  epu_own_o
);

  import mem_pkg::*;

  own_state_t           state_q;
  own_state_t           state_d;
  ram_req_t             ram_req;
  epu_pkg::weight_vec_t ram_rdata;
  logic                 wsel;
  logic                 host_rd;

  // host strobes count here only when aimed at the weight buffer
  assign wsel = (host_i.buf_sel == 1'b0);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE, EPU_RW: begin
        // no takeover while a run is reading the buffer
        if (wsel && host_i.load_begin && !busy_i) state_d = HOST_W;
      end
      HOST_W: begin
        if (wsel && host_i.load_done) state_d = EPU_RW;
      end
      default: state_d = IDLE;
    endcase
  end

  // sram port mux
  always_comb begin
    ram_req = '0;
    case (state_q)
      HOST_W: begin
        ram_req.cs    = wsel && (host_i.wr || host_i.rd);
        ram_req.we    = wsel && host_i.wr;
        ram_req.addr  = host_i.addr;
        ram_req.wdata = host_i.wdata;
      end
      EPU_RW: ram_req = epu_req_i;
      default: ram_req = '0;
    endcase
  end

  // readback, a write in the same cycle takes the port
  assign host_rd = (state_q == HOST_W) && wsel && host_i.rd && !host_i.wr;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rvalid_o <= 1'b0;
    end else begin
      rvalid_o <= host_rd;
    end
  end

  assign rdata_o   = rvalid_o ? ram_rdata : '0;
  assign weight_o  = (state_q == EPU_RW) ? ram_rdata : '0;
  assign epu_own_o = (state_q == EPU_RW);

  sp_ram #(
    .word_t(epu_pkg::weight_vec_t),
    .DEPTH (`BUF_DEPTH)
  ) weight_ram_i (
    .clk    (clk),
    .req_i  (ram_req),
    .rdata_o(ram_rdata)
  );

endmodule

// ==== design/epu_ctrl.sv ====
`timescale 1ns/1ps
`include "conv_acc_defs.svh"

module epu_ctrl (
  input  logic                 clk,
  input  logic                 rst,
  input  mem_pkg::host_req_t   host_i,
  input  logic                 start_i,
  input  logic [`LEN_BITS-1:0] len_i,
  input  logic                 epu_own_i,
  output mem_pkg::ram_req_t    wbuf_req_o,
  output mem_pkg::ram_req_t    fbuf_req_o,
  output logic                 mac_valid_o,
  output logic                 mac_first_o,
  output logic                 busy_o,
  output logic                 done_o
);

  import epu_pkg::*;

  epu_state_t           state_q;
  logic [`LEN_BITS-1:0] cnt_q;
  logic [`LEN_BITS-1:0] len_q;
  logic                 start_ok;
  logic                 last_word;
  logic                 valid_q;
  logic                 first_q;
  logic                 last_q;

  // zero length would never reach its last word
  assign start_ok  = start_i && epu_own_i && (state_q == IDLE) && (len_i != '0);
  assign last_word = (cnt_q == len_q - 1'b1);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state_q <= IDLE;
      cnt_q   <= '0;
      len_q   <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (start_ok) begin
            state_q <= RUN;
            cnt_q   <= '0;
            len_q   <= len_i;
          end
        end
        RUN: begin
          cnt_q <= cnt_q + 1'b1;
          if (last_word) state_q <= DRAIN;
        end
        // one cycle for the last word to come back from the rams
        DRAIN: state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  // flags follow the ram read latency
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      valid_q <= 1'b0;
      first_q <= 1'b0;
      last_q  <= 1'b0;
      done_o  <= 1'b0;
    end else begin
      valid_q <= (state_q == RUN);
      first_q <= (state_q == RUN) && (cnt_q == '0);
      last_q  <= (state_q == RUN) && last_word;
      done_o  <= valid_q && last_q;
    end
  end

  assign mac_valid_o = valid_q;
  assign mac_first_o = first_q;
  assign busy_o      = (state_q != IDLE);

  // weight reads, only while running
  always_comb begin
    wbuf_req_o      = '0;
    wbuf_req_o.cs   = (state_q == RUN);
    wbuf_req_o.addr = cnt_q[`BUF_ADDR_BITS-1:0];
  end

  // feature port: host writes when idle, engine reads otherwise
  always_comb begin
    fbuf_req_o = '0;
    if (state_q == IDLE) begin
      fbuf_req_o.cs    = host_i.wr && host_i.buf_sel;
      fbuf_req_o.we    = host_i.wr && host_i.buf_sel;
      fbuf_req_o.addr  = host_i.addr;
      fbuf_req_o.wdata = host_i.wdata;
    end else begin
      fbuf_req_o.cs   = (state_q == RUN);
      fbuf_req_o.addr = cnt_q[`BUF_ADDR_BITS-1:0];
    end
  end

endmodule

// ==== design/mac_array.sv ====
`timescale 1ns/1ps
`include "conv_acc_defs.svh"

module mac_array (
  input  logic                 clk,
  input  logic                 rst,
  input  epu_pkg::weight_vec_t weight_i,
  input  epu_pkg::feat_vec_t   feat_i,
  input  logic                 valid_i,
  input  logic                 first_i,
  input  logic                 done_i,
  output epu_pkg::acc_t        result_o
);

  import epu_pkg::*;

  prod_t prod [`LANES];
  acc_t  lane_sum;
  acc_t  acc_q;
  acc_t  res_q;

  // feature gets a zero msb so it multiplies as a positive signed value
  always_comb begin
    lane_sum = '0;
    for (int l = 0; l < `LANES; l++) begin
      prod[l]  = $signed(weight_i[l]) * $signed({1'b0, feat_i[l]});
      lane_sum = lane_sum + acc_t'(prod[l]);
    end
  end

  // first word restarts the sum
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      acc_q <= '0;
    end else if (valid_i) begin
      if (first_i) begin
        acc_q <= lane_sum;
      end else begin
        acc_q <= acc_q + lane_sum;
      end
    end
  end

  // held until the next done
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      res_q <= '0;
    end else if (done_i) begin
      res_q <= acc_q;
    end
  end

  // the last word is already summed while done is high
  assign result_o = done_i ? acc_q : res_q;

endmodule

// ==== design/conv_acc_top.sv ====
`timescale 1ns/1ps
`include "conv_acc_defs.svh"

module conv_acc_top (
  input  logic                  clk,
  input  logic                  rst,
  input  mem_pkg::host_req_t    host_i,
  input  logic                  start_i,
  input  logic [`LEN_BITS-1:0]  len_i,
  output logic                  rvalid_o,
  output logic [`DATA_BITS-1:0] rdata_o,
  output logic                  busy_o,
  output logic                  done_o,
  output logic                  epu_own_o,
  output epu_pkg::acc_t         result_o
);

  import mem_pkg::*;
  import epu_pkg::*;

  ram_req_t    wbuf_req;
  ram_req_t    fbuf_req;
  weight_vec_t weight;
  feat_vec_t   feat;
  logic        mac_valid;
  logic        mac_first;

  weight_wrapper weight_wrapper_i (
    .clk      (clk),
    .rst      (rst),
    .host_i   (host_i),
    .busy_i   (busy_o),
    .epu_req_i(wbuf_req),
    .weight_o (weight),
    .rvalid_o (rvalid_o),
    .rdata_o  (rdata_o),
    .epu_own_o(epu_own_o)
  );

  epu_ctrl epu_ctrl_i (
    .clk        (clk),
    .rst        (rst),
    .host_i     (host_i),
    .start_i    (start_i),
    .len_i      (len_i),
    .epu_own_i  (epu_own_o),
    .wbuf_req_o (wbuf_req),
    .fbuf_req_o (fbuf_req),
    .mac_valid_o(mac_valid),
    .mac_first_o(mac_first),
    .busy_o     (busy_o),
    .done_o     (done_o)
  );

  // feature buffer, port owned by epu_ctrl
  sp_ram #(
    .word_t(feat_vec_t),
    .DEPTH (`BUF_DEPTH)
  ) feat_ram_i (
    .clk    (clk),
    .req_i  (fbuf_req),
    .rdata_o(feat)
  );

  mac_array mac_array_i (
    .clk     (clk),
    .rst     (rst),
    .weight_i(weight),
    .feat_i  (feat),
    .valid_i (mac_valid),
    .first_i (mac_first),
    .done_i  (done_o),
    .result_o(result_o)
  );

endmodule

// ==== dv/conv_acc_tb.sv ====
`timescale 1ns/1ps
`include "conv_acc_defs.svh"

module conv_acc_tb;

  import mem_pkg::*;
  import epu_pkg::*;

  localparam int N_RUNS = 8;

  logic                  clk;
  logic                  rst;
  host_req_t             host_i;
  logic                  start_i;
  logic [`LEN_BITS-1:0]  len_i;
  logic                  rvalid_o;
  logic [`DATA_BITS-1:0] rdata_o;
  logic                  busy_o;
  logic                  done_o;
  logic                  epu_own_o;
  acc_t                  result_o;

  // expected levels driven on the falling edge
  logic                  busy_exp;
  logic                  done_exp;
  logic                  own_exp;
  logic                  rv_exp;
  logic [`DATA_BITS-1:0] rd_word_exp;
  acc_t                  res_exp;

  logic [`DATA_BITS-1:0] wshadow [`BUF_DEPTH];
  logic [`DATA_BITS-1:0] fshadow [`BUF_DEPTH];
  int                    run_len [N_RUNS];
  int                    seed;
  int                    errors;
  int                    err_mark;
  int                    tests_run;
  int                    tests_failed;
  int                    limit_cycles;

  conv_acc_top conv_acc_top_i (
    .clk      (clk),
    .rst      (rst),
    .host_i   (host_i),
    .start_i  (start_i),
    .len_i    (len_i),
    .rvalid_o (rvalid_o),
    .rdata_o  (rdata_o),
    .busy_o   (busy_o),
    .done_o   (done_o),
    .epu_own_o(epu_own_o),
    .result_o (result_o)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("mismatch at time %0t: %s got %h expected %h", $time, name, got, exp);
    errors++;
  endtask

  task automatic report_failure(input string msg);
    $display("error at time %0t: %s", $time, msg);
    errors++;
  endtask

  result_chk: assert property (@(posedge clk) disable iff (rst) result_o == res_exp)
    else report_mismatch("result_o", $sampled(result_o), $sampled(res_exp));
  done_chk: assert property (@(posedge clk) disable iff (rst) done_o == done_exp)
    else report_mismatch("done_o", 32'($sampled(done_o)), 32'($sampled(done_exp)));
  busy_chk: assert property (@(posedge clk) disable iff (rst) busy_o == busy_exp)
    else report_mismatch("busy_o", 32'($sampled(busy_o)), 32'($sampled(busy_exp)));
  own_chk: assert property (@(posedge clk) disable iff (rst) epu_own_o == own_exp)
    else report_mismatch("epu_own_o", 32'($sampled(epu_own_o)), 32'($sampled(own_exp)));
  rvalid_chk: assert property (@(posedge clk) disable iff (rst) rvalid_o == rv_exp)
    else report_mismatch("rvalid_o", 32'($sampled(rvalid_o)), 32'($sampled(rv_exp)));
  // rdata_o reads zero outside a readback pulse
  rdata_chk: assert property (@(posedge clk) disable iff (rst)
                              rdata_o == (rv_exp ? rd_word_exp : '0))
    else report_mismatch("rdata_o", $sampled(rdata_o),
                         $sampled(rv_exp) ? $sampled(rd_word_exp) : '0);

  // wrapping sum of signed weight byte times unsigned feature byte
  function automatic acc_t dot_model(input int len);
    acc_t              sum;
    logic signed [7:0] w;
    logic [7:0]        f;
    sum = '0;
    for (int k = 0; k < len; k++) begin
      for (int l = 0; l < `LANES; l++) begin
        w   = wshadow[k][`LANE_BITS*l +: `LANE_BITS];
        f   = fshadow[k][`LANE_BITS*l +: `LANE_BITS];
        sum = sum + acc_t'(int'(w) * int'(f));
      end
    end
    return sum;
  endfunction

  task automatic write_word(input logic sel, input int addr, input logic [31:0] data);
    @(negedge clk);
    host_i         = '0;
    host_i.wr      = 1'b1;
    host_i.buf_sel = sel;
    host_i.addr    = addr[`BUF_ADDR_BITS-1:0];
    host_i.wdata   = data;
    @(negedge clk);
    host_i = '0;
  endtask

  task automatic read_weight(input int addr);
    @(negedge clk);
    host_i      = '0;
    host_i.rd   = 1'b1;
    host_i.addr = addr[`BUF_ADDR_BITS-1:0];
    @(negedge clk);
    host_i      = '0;
    rv_exp      = 1'b1;
    rd_word_exp = wshadow[addr];
    @(negedge clk);
    rv_exp = 1'b0;
  endtask

  task automatic take_buffer();
    @(negedge clk);
    host_i            = '0;
    host_i.load_begin = 1'b1;
    @(negedge clk);
    host_i  = '0;
    own_exp = 1'b0;
  endtask

  task automatic release_buffer();
    @(negedge clk);
    host_i           = '0;
    host_i.load_done = 1'b1;
    @(negedge clk);
    host_i  = '0;
    own_exp = 1'b1;
  endtask

  // start while the host holds the weights has no effect
  task automatic start_rejected(input int len);
    @(negedge clk);
    start_i = 1'b1;
    len_i   = len[`LEN_BITS-1:0];
    @(negedge clk);
    start_i = 1'b0;
    repeat (len + 2) @(negedge clk);
  endtask

  // mid 1 tries load_begin during the run and mid 2 a feature write
  task automatic run_dot(input int len, input int mid);
    acc_t next_res;
    int   cyc;
    bit   seen;
    next_res = dot_model(len);
    cyc      = 0;
    seen     = 1'b0;
    @(negedge clk);
    start_i = 1'b1;
    len_i   = len[`LEN_BITS-1:0];
    while (!seen && cyc < len + 8) begin
      @(negedge clk);
      cyc++;
      start_i = 1'b0;
      if (cyc == 1) busy_exp = 1'b1;
      if (cyc == 2 && mid == 1) host_i.load_begin = 1'b1;
      // word 0 is read by every run
      if (cyc == 2 && mid == 2) begin
        host_i.wr      = 1'b1;
        host_i.buf_sel = 1'b1;
        host_i.addr    = '0;
        host_i.wdata   = ~fshadow[0];
      end
      if (cyc == 3) host_i = '0;
      if (cyc == len + 2) begin
        busy_exp = 1'b0;
        done_exp = 1'b1;
        res_exp  = next_res;
      end
      seen = done_o;
    end
    if (!seen) begin
      report_failure($sformatf("done_o never came for a run of length %0d", len));
      busy_exp = 1'b0;
    end
    @(negedge clk);
    host_i   = '0;
    done_exp = 1'b0;
  endtask

  task automatic finish_test(input string name);
    // let the last sampled edges report first
    repeat (2) @(negedge clk);
    tests_run++;
    if (errors != err_mark) begin
      tests_failed++;
      $display("test %0d %s: failed, %0d errors", tests_run, name, errors - err_mark);
    end else begin
      $display("test %0d %s: ok", tests_run, name);
    end
    err_mark = errors;
  endtask

  initial begin
    int                    sum_len;
    int                    a;
    logic [`DATA_BITS-1:0] v;
    seed         = 32'h92d6_9b83;
    errors       = 0;
    err_mark     = 0;
    tests_run    = 0;
    tests_failed = 0;
    rst          = 1'b1;
    host_i       = '0;
    start_i      = 1'b0;
    len_i        = '0;
    busy_exp     = 1'b0;
    done_exp     = 1'b0;
    own_exp      = 1'b0;
    rv_exp       = 1'b0;
    rd_word_exp  = '0;
    res_exp      = '0;
    sum_len      = 0;
    for (int i = 0; i < N_RUNS; i++) begin
      run_len[i] = 1 + int'($unsigned($random(seed)) % `BUF_DEPTH);
    end
    // both ends of the legal length range
    run_len[3] = 1;
    run_len[4] = `BUF_DEPTH;
    run_len[6] = `BUF_DEPTH;
    run_len[7] = 1;
    for (int i = 0; i < N_RUNS; i++) begin
      sum_len += run_len[i] + 6;
    end
    limit_cycles = 2 * (16 + 7 * `BUF_DEPTH + sum_len) + 400;
    fork
      begin
        repeat (limit_cycles) @(posedge clk);
        $display("error: watchdog expired after %0d cycles", limit_cycles);
        $display("SOME TESTS FAILED");
        $finish;
      end
    join_none

    repeat (16) @(negedge clk);
    rst = 1'b0;
    repeat (3) @(negedge clk);
    finish_test("reset levels");

    take_buffer();
    for (int i = 0; i < `BUF_DEPTH; i++) begin
      v = $random(seed);
      write_word(1'b0, i, v);
      wshadow[i] = v;
    end
    for (int i = 0; i < `BUF_DEPTH; i++) begin
      read_weight(i);
    end
    finish_test("weight load and readback");

    start_rejected(run_len[5]);
    release_buffer();
    for (int i = 0; i < `BUF_DEPTH; i++) begin
      v = $random(seed);
      write_word(1'b1, i, v);
      fshadow[i] = v;
    end
    // the engine owns the weights so this write is lost
    a = int'($unsigned($random(seed)) % `BUF_DEPTH);
    write_word(1'b0, a, ~wshadow[a]);
    take_buffer();
    read_weight(a);
    release_buffer();
    run_dot(run_len[0], 1);
    run_dot(run_len[1], 2);
    run_dot(run_len[2], 0);
    finish_test("ownership rules");

    run_dot(run_len[3], 0);
    run_dot(run_len[4], 0);
    run_dot(run_len[5], 0);
    finish_test("dot product runs");

    run_dot(run_len[6], 0);
    run_dot(run_len[7], 0);
    finish_test("back to back runs");

    $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+design
design/mem_pkg.sv
design/epu_pkg.sv
design/sp_ram.sv
design/weight_wrapper.sv
design/epu_ctrl.sv
design/mac_array.sv
design/conv_acc_top.sv
dv/conv_acc_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module conv_acc_tb \
  -f filelist.f -o conv_acc_sim

./obj_dir/conv_acc_sim | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
  echo "simulation result: pass"
  exit 0
else
  echo "simulation result: fail"
  exit 1
fi
